// File: hdl/core_wb_config.svh
`ifndef CORE_WB_CONFIG_SVH
`define CORE_WB_CONFIG_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------

`define CORE_XLEN           64        // Data word width
`define CORE_REG_AW         5         // GPR address width

// ----------------------------------------------------------
// Machine mode CSRs held in the writeback stage
// ----------------------------------------------------------

`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342

`define CORE_MTVEC_RESET    64'h0000_0000_0000_0100 // Trap vector after reset

`endif

// File: hdl/core_wb_pkg.sv
`include "core_wb_config.svh"

package core_wb_pkg;

    // ----------------------------------------------------------
    // Operation encodings from stage 3
    // ----------------------------------------------------------

    // Source of the register write data
    typedef enum logic [1:0] {
        WB_OP_NONE  = 2'd0,
        WB_OP_WDATA = 2'd1,
        WB_OP_LSU   = 2'd2,
        WB_OP_CSR   = 2'd3
    } wb_op_e;

    typedef struct packed {
        logic is_load;
        logic is_store;
        logic is_byte;
        logic is_half;
        logic is_word;
        logic is_double;
        logic sext;          // Sign extend loaded data
    } lsu_op_t;

    typedef struct packed {
        logic rd;
        logic wr;
        logic set;
        logic clr;
    } csr_op_t;

    typedef enum logic {
        CFU_OP_NONE = 1'b0,
        CFU_OP_MRET = 1'b1
    } cfu_op_e;

    // ----------------------------------------------------------
    // Trap causes
    // ----------------------------------------------------------

    typedef logic [6:0] trap_cause_t;

    localparam trap_cause_t CAUSE_ILLEGAL_INSTR = 7'd2;

    // Earlier stages park the exception code in rd when s3_trap is set
    typedef union packed {
        logic [`CORE_REG_AW-1:0] addr;      // Destination register
        logic [4:0]              cause_lo;  // Low bits of the trap cause
    } rd_field_u;

endpackage

// File: hdl/wb_csr_if.sv
`timescale 1ns/1ps
`include "core_wb_config.svh"

interface wb_csr_if;
    import core_wb_pkg::*;

    logic                  csr_en;      // One access per instruction
    logic                  csr_wr;
    logic                  csr_set;
    logic                  csr_clr;
    logic [11:0]           csr_addr;
    logic [`CORE_XLEN-1:0] csr_wdata;
    logic [`CORE_XLEN-1:0] csr_rdata;   // Value before the update
    logic                  csr_trap;    // Current or held access error
    logic                  trap_take;   // Control flow change edge
    logic [`CORE_XLEN-1:0] trap_pc;
    trap_cause_t           trap_cause;
    logic                  new_instr;
    logic [`CORE_XLEN-1:0] mtvec;

    modport commit (
        output csr_en, csr_wr, csr_set, csr_clr, csr_addr, csr_wdata,
        output trap_take, trap_pc, trap_cause, new_instr,
        input  csr_rdata, csr_trap, mtvec
    );

    modport csr (
        input  csr_en, csr_wr, csr_set, csr_clr, csr_addr, csr_wdata,
        input  trap_take, trap_pc, trap_cause, new_instr,
        output csr_rdata, csr_trap, mtvec
    );

endinterface

// File: hdl/wb_load_align.sv
`timescale 1ns/1ps
`include "core_wb_config.svh"

module wb_load_align (
    input  logic [2:0]             addr_lo,
    input  core_wb_pkg::lsu_op_t   lsu_op,
    input  logic [`CORE_XLEN-1:0]  dmem_rdata,
    output logic [`CORE_XLEN-1:0]  load_data
);
    import core_wb_pkg::*;

    logic [5:0]            data_shift;
    logic [`CORE_XLEN-1:0] rdata_shifted;

    // Keep the low bits and fill the rest with zeros or the sign
    function automatic logic [`CORE_XLEN-1:0] fit(
        input logic [`CORE_XLEN-1:0] value,
        input int unsigned           bits,
        input logic                  sx
    );
        logic [`CORE_XLEN-1:0] mask;
        logic                  sign;
        mask = {`CORE_XLEN{1'b1}} >> (`CORE_XLEN - bits);
        sign = sx && value[bits-1];
        return (value & mask) | ({`CORE_XLEN{sign}} & ~mask);
    endfunction

    assign data_shift    = {addr_lo, 3'b000};         // Byte offset in bits
    assign rdata_shifted = dmem_rdata >> data_shift;

    always_comb begin
        if (lsu_op.is_byte) begin
            load_data = fit(rdata_shifted, 8, lsu_op.sext);
        end else if (lsu_op.is_half) begin
            load_data = fit(rdata_shifted, 16, lsu_op.sext);
        end else if (lsu_op.is_word) begin
            load_data = fit(rdata_shifted, 32, lsu_op.sext);
        end else if (lsu_op.is_double) begin
            load_data = dmem_rdata;                   // Full word, no shift
        end else begin
            load_data = '0;
        end
    end

endmodule

// File: hdl/wb_csr_unit.sv
`timescale 1ns/1ps
`include "core_wb_config.svh"

module wb_csr_unit (
    input  logic   g_clk,
    input  logic   g_resetn,
    wb_csr_if.csr  csr
);
    import core_wb_pkg::*;

    logic [`CORE_XLEN-1:0] mscratch;
    logic [`CORE_XLEN-1:0] mtvec;
    logic [`CORE_XLEN-1:0] mepc;
    logic [`CORE_XLEN-1:0] mcause;
    logic [`CORE_XLEN-1:0] rdata;
    logic [`CORE_XLEN-1:0] wval;
    logic                  hit;
    logic                  do_write;
    logic                  err_held;

    // ----------------------------------------------------------
    // Read decode
    // ----------------------------------------------------------

    always_comb begin
        hit = 1'b1;
        case (csr.csr_addr)
            `CSR_ADDR_MSCRATCH: rdata = mscratch;
            `CSR_ADDR_MTVEC:    rdata = mtvec;
            `CSR_ADDR_MEPC:     rdata = mepc;
            `CSR_ADDR_MCAUSE:   rdata = mcause;
            default: begin
                rdata = '0;
                hit   = 1'b0;                         // Not implemented here
            end
        endcase
    end

    assign wval = csr.csr_wr  ? csr.csr_wdata :
                  csr.csr_set ? (rdata | csr.csr_wdata) :
                  csr.csr_clr ? (rdata & ~csr.csr_wdata) :
                                rdata;

    assign do_write = csr.csr_en && hit && (csr.csr_wr || csr.csr_set || csr.csr_clr);

    assign csr.csr_rdata = rdata;
    assign csr.csr_trap  = (csr.csr_en && !hit) || err_held;
    assign csr.mtvec     = mtvec;

    // ----------------------------------------------------------
    // Register update
    // ----------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mtvec    <= `CORE_MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
        end else begin
            if (do_write) begin
                case (csr.csr_addr)
                    `CSR_ADDR_MSCRATCH: mscratch <= wval;
                    `CSR_ADDR_MTVEC:    mtvec    <= wval;
                    `CSR_ADDR_MEPC:     mepc     <= wval;
                    default:            mcause   <= wval;
                endcase
            end
            if (csr.trap_take) begin                  // Trap wins over the access
                mepc   <= csr.trap_pc;
                mcause <= {{(`CORE_XLEN - 7){1'b0}}, csr.trap_cause};
            end
        end
    end

    // Error stays up for the rest of the instruction
    always_ff @(posedge g_clk) begin
        if (!g_resetn || csr.new_instr) begin
            err_held <= 1'b0;
        end else if (csr.csr_en) begin
            err_held <= !hit;
        end
    end

    a_one_access: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr.csr_en && !csr.new_instr |=> !csr.csr_en);

endmodule

// File: hdl/wb_commit.sv
`timescale 1ns/1ps
`include "core_wb_config.svh"

module wb_commit (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     s3_valid,
    input  logic                     s3_full,
    input  logic [`CORE_XLEN-1:0]    s3_pc,
    input  logic [31:0]              s3_instr,
    input  logic [`CORE_XLEN-1:0]    s3_wdata,
    input  core_wb_pkg::rd_field_u   s3_rd,
    input  core_wb_pkg::lsu_op_t     s3_lsu_op,
    input  core_wb_pkg::csr_op_t     s3_csr_op,
    input  logic [11:0]              s3_csr_addr,
    input  core_wb_pkg::cfu_op_e     s3_cfu_op,
    input  core_wb_pkg::wb_op_e      s3_wb_op,
    input  logic                     s3_trap,
    input  logic [`CORE_XLEN-1:0]    load_data,
    input  logic                     int_pending,
    input  core_wb_pkg::trap_cause_t int_cause,
    input  logic [`CORE_XLEN-1:0]    int_tvec,
    input  logic                     s3_cf_ack,
    wb_csr_if.commit                 csr,
    output logic                     s3_ready,
    output logic                     s3_cf_valid,
    output logic [`CORE_XLEN-1:0]    s3_cf_target,
    output logic                     int_ack,
    output logic                     s3_rd_wen,
    output logic [`CORE_REG_AW-1:0]  s3_rd_addr,
    output logic [`CORE_XLEN-1:0]    s3_rd_wdata,
    output logic                     trap_cpu,
    output logic                     trap_int,
    output core_wb_pkg::trap_cause_t trap_cause,
    output logic [`CORE_XLEN-1:0]    trap_pc,
    output logic                     exec_mret,
    output logic                     instr_ret,
    output logic                     trs_valid,
    output logic [31:0]              trs_instr,
    output logic [`CORE_XLEN-1:0]    trs_pc
);
    import core_wb_pkg::*;

    logic wb_first;       // First cycle of the instruction
    logic cf_done;        // One change per instruction
    logic trapped_q;      // CPU trap already taken
    logic e_new_instr;
    logic e_cf_change;
    logic cfu_wait;
    logic raise_int;
    logic lsu_wen;
    logic gpr_write;

    // ----------------------------------------------------------
    // Stage handshake and retirement
    // ----------------------------------------------------------

    assign e_new_instr = s3_valid && s3_ready;
    assign e_cf_change = s3_cf_valid && s3_cf_ack;
    assign cfu_wait    = s3_cf_valid && !s3_cf_ack;
    assign s3_ready    = !s3_full || !cfu_wait;

    // A trapped instruction retires at its change and not again
    assign instr_ret = (e_new_instr && s3_full && !trapped_q) ||
                       (e_cf_change && trap_cpu);
    assign exec_mret = (s3_cfu_op == CFU_OP_MRET) && instr_ret;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wb_first  <= 1'b0;
            cf_done   <= 1'b0;
            trapped_q <= 1'b0;
        end else begin
            wb_first <= e_new_instr;
            if (e_new_instr) begin
                cf_done   <= 1'b0;
                trapped_q <= 1'b0;
            end else if (e_cf_change) begin
                cf_done   <= 1'b1;
                trapped_q <= trap_cpu;
            end
        end
    end

    // ----------------------------------------------------------
    // Register writeback
    // ----------------------------------------------------------

    assign lsu_wen   = (s3_wb_op == WB_OP_LSU) && s3_lsu_op.is_load && !s3_lsu_op.is_store;
    assign gpr_write = (s3_wb_op == WB_OP_WDATA) || (s3_wb_op == WB_OP_CSR) || lsu_wen;

    assign s3_rd_wen  = wb_first && s3_full && gpr_write && !trap_cpu;
    assign s3_rd_addr = s3_rd.addr;

    always_comb begin
        case (s3_wb_op)
            WB_OP_WDATA: s3_rd_wdata = s3_wdata;
            WB_OP_LSU:   s3_rd_wdata = load_data;
            WB_OP_CSR:   s3_rd_wdata = csr.csr_rdata;
            default:     s3_rd_wdata = '0;
        endcase
    end

    // CSR access, once per instruction
    assign csr.csr_en     = wb_first && s3_full &&
                            (s3_csr_op.rd || s3_csr_op.wr || s3_csr_op.set || s3_csr_op.clr);
    assign csr.csr_wr     = s3_csr_op.wr;
    assign csr.csr_set    = s3_csr_op.set;
    assign csr.csr_clr    = s3_csr_op.clr;
    assign csr.csr_addr   = s3_csr_addr;
    assign csr.csr_wdata  = s3_wdata;
    assign csr.new_instr  = e_new_instr;
    assign csr.trap_take  = e_cf_change;
    assign csr.trap_pc    = s3_pc;
    assign csr.trap_cause = trap_cause;

    // ----------------------------------------------------------
    // Traps and interrupts
    // ----------------------------------------------------------

    assign raise_int = int_pending && s3_full;    // Interrupt beats CPU trap
    assign trap_cpu  = !raise_int && s3_full && (s3_trap || csr.csr_trap);
    assign int_ack   = raise_int && e_cf_change;
    assign trap_int  = int_ack;
    assign trap_pc   = s3_pc;

    assign trap_cause = raise_int    ? int_cause :
                        s3_trap      ? {2'b00, s3_rd.cause_lo} :
                        csr.csr_trap ? CAUSE_ILLEGAL_INSTR :
                                       '0;

    assign s3_cf_valid  = !cf_done && (trap_cpu || raise_int);
    assign s3_cf_target = raise_int ? int_tvec : csr.mtvec;

    // Trace of each retired instruction
    assign trs_valid = instr_ret;
    assign trs_instr = s3_instr;
    assign trs_pc    = s3_pc;

    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_cf_valid && !s3_cf_ack |=> s3_cf_valid);

    // An instruction that wrote its register does not trap afterwards
    a_no_wen_on_trap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_rd_wen && !e_new_instr |=> !trap_cpu);

endmodule

// File: hdl/core_wb_top.sv
`timescale 1ns/1ps
`include "core_wb_config.svh"

module core_wb_top (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     s3_valid,
    output logic                     s3_ready,
    input  logic                     s3_full,
    input  logic [`CORE_XLEN-1:0]    s3_pc,
    input  logic [31:0]              s3_instr,
    input  logic [`CORE_XLEN-1:0]    s3_wdata,
    input  logic [`CORE_REG_AW-1:0]  s3_rd,
    input  core_wb_pkg::lsu_op_t     s3_lsu_op,
    input  core_wb_pkg::csr_op_t     s3_csr_op,
    input  logic [11:0]              s3_csr_addr,
    input  core_wb_pkg::cfu_op_e     s3_cfu_op,
    input  core_wb_pkg::wb_op_e      s3_wb_op,
    input  logic                     s3_trap,
    input  logic [`CORE_XLEN-1:0]    dmem_rdata,
    input  logic                     int_pending,
    input  core_wb_pkg::trap_cause_t int_cause,
    input  logic [`CORE_XLEN-1:0]    int_tvec,
    output logic                     int_ack,
    output logic                     s3_cf_valid,
    input  logic                     s3_cf_ack,
    output logic [`CORE_XLEN-1:0]    s3_cf_target,
    output logic                     s3_rd_wen,
    output logic [`CORE_REG_AW-1:0]  s3_rd_addr,
    output logic [`CORE_XLEN-1:0]    s3_rd_wdata,
    output logic                     trap_cpu,
    output logic                     trap_int,
    output core_wb_pkg::trap_cause_t trap_cause,
    output logic [`CORE_XLEN-1:0]    trap_pc,
    output logic                     exec_mret,
    output logic                     instr_ret,
    output logic                     trs_valid,
    output logic [31:0]              trs_instr,
    output logic [`CORE_XLEN-1:0]    trs_pc
);

    logic [`CORE_XLEN-1:0] load_data;

    wb_csr_if i_csr_if ();

    wb_load_align i_load_align (
        .addr_lo    (s3_wdata[2:0]),    // Low address bits of the load
        .lsu_op     (s3_lsu_op),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    wb_csr_unit i_csr_unit (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (i_csr_if.csr)
    );

    wb_commit i_commit (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s3_valid     (s3_valid),
        .s3_full      (s3_full),
        .s3_pc        (s3_pc),
        .s3_instr     (s3_instr),
        .s3_wdata     (s3_wdata),
        .s3_rd        (s3_rd),
        .s3_lsu_op    (s3_lsu_op),
        .s3_csr_op    (s3_csr_op),
        .s3_csr_addr  (s3_csr_addr),
        .s3_cfu_op    (s3_cfu_op),
        .s3_wb_op     (s3_wb_op),
        .s3_trap      (s3_trap),
        .load_data    (load_data),
        .int_pending  (int_pending),
        .int_cause    (int_cause),
        .int_tvec     (int_tvec),
        .s3_cf_ack    (s3_cf_ack),
        .csr          (i_csr_if.commit),
        .s3_ready     (s3_ready),
        .s3_cf_valid  (s3_cf_valid),
        .s3_cf_target (s3_cf_target),
        .int_ack      (int_ack),
        .s3_rd_wen    (s3_rd_wen),
        .s3_rd_addr   (s3_rd_addr),
        .s3_rd_wdata  (s3_rd_wdata),
        .trap_cpu     (trap_cpu),
        .trap_int     (trap_int),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .exec_mret    (exec_mret),
        .instr_ret    (instr_ret),
        .trs_valid    (trs_valid),
        .trs_instr    (trs_instr),
        .trs_pc       (trs_pc)
    );

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;               // 20 ns period
    end

    initial begin
        g_resetn = 1'b0;
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
    end

endmodule

// File: sim/tb_core_wb.sv
`timescale 1ns/1ps
`include "core_wb_config.svh"

module tb_core_wb;
    import core_wb_pkg::*;

    localparam int unsigned MAX_CYCLES = 400;
    localparam int unsigned SEED       = 32'hbc61_c1bd;
    localparam lsu_op_t     NO_LSU     = '0;
    localparam csr_op_t     NO_CSR     = '0;

    logic                    g_clk;
    logic                    g_resetn;
    logic                    s3_valid;
    logic                    s3_ready;
    logic                    s3_full;
    logic [`CORE_XLEN-1:0]   s3_pc;
    logic [31:0]             s3_instr;
    logic [`CORE_XLEN-1:0]   s3_wdata;
    logic [`CORE_REG_AW-1:0] s3_rd;
    lsu_op_t                 s3_lsu_op;
    csr_op_t                 s3_csr_op;
    logic [11:0]             s3_csr_addr;
    cfu_op_e                 s3_cfu_op;
    wb_op_e                  s3_wb_op;
    logic                    s3_trap;
    logic [`CORE_XLEN-1:0]   dmem_rdata;
    logic                    int_pending;
    trap_cause_t             int_cause;
    logic [`CORE_XLEN-1:0]   int_tvec;
    logic                    int_ack;
    logic                    s3_cf_valid;
    logic                    s3_cf_ack;
    logic [`CORE_XLEN-1:0]   s3_cf_target;
    logic                    s3_rd_wen;
    logic [`CORE_REG_AW-1:0] s3_rd_addr;
    logic [`CORE_XLEN-1:0]   s3_rd_wdata;
    logic                    trap_cpu;
    logic                    trap_int;
    trap_cause_t             trap_cause;
    logic [`CORE_XLEN-1:0]   trap_pc;
    logic                    exec_mret;
    logic                    instr_ret;
    logic                    trs_valid;
    logic [31:0]             trs_instr;
    logic [`CORE_XLEN-1:0]   trs_pc;

    int unsigned             cycle_count = 0;
    logic [`CORE_XLEN-1:0]   pc_next = 64'h0000_0000_8000_0000;
    logic                    prev_live = 1'b0;   // Instruction in stage still to retire
    logic                    prev_mret = 1'b0;
    logic [`CORE_XLEN-1:0]   prev_pc;
    logic [31:0]             prev_instr;

    tb_clkgen i_clkgen (.g_clk(g_clk), .g_resetn(g_resetn));

    core_wb_top i_dut (.*);

    always @(posedge g_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic check_data(input string name, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input logic [`CORE_REG_AW-1:0] got,
                              input logic [`CORE_REG_AW-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_cause(input string name, input trap_cause_t got,
                               input trap_cause_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------

    // Shift by the byte offset, keep the access size, then extend
    function automatic logic [`CORE_XLEN-1:0] aligned_load(input logic [`CORE_XLEN-1:0] word,
                                                           input int off, input int nbytes,
                                                           input logic sx);
        logic [`CORE_XLEN-1:0] field;
        logic [`CORE_XLEN-1:0] keep;
        if (nbytes == 8) begin
            return word;                              // Double ignores the offset
        end
        field = word >> (8 * off);
        keep  = (64'd1 << (8 * nbytes)) - 64'd1;
        field = field & keep;
        if (sx && field[8 * nbytes - 1]) begin
            field = field | ~keep;
        end
        return field;
    endfunction

    task automatic next_cycle();
        @(posedge g_clk);
        #2;                                           // Drive point
    endtask

    // Starts at a drive point, returns at the sample point of the first cycle
    task automatic send_instr(input wb_op_e wb_op, input logic [`CORE_XLEN-1:0] wdata,
                              input logic [`CORE_REG_AW-1:0] rd, input lsu_op_t lsu,
                              input csr_op_t cop, input logic [11:0] caddr,
                              input cfu_op_e cfu, input logic trap, input logic irq);
        s3_valid = 1'b1;
        #8;
        while (!s3_ready) begin
            @(posedge g_clk);
            #10;
        end
        check_bit("instr_ret", instr_ret, prev_live);  // Retire of the replaced instr
        check_bit("trs_valid", trs_valid, prev_live);
        check_bit("exec_mret", exec_mret, prev_live && prev_mret);
        if (prev_live) begin
            check_data("trs_pc", trs_pc, prev_pc);
            check_data("trs_instr", {32'd0, trs_instr}, {32'd0, prev_instr});
        end
        next_cycle();
        pc_next     = pc_next + 64'd4;
        s3_valid    = 1'b0;
        s3_full     = 1'b1;
        s3_pc       = pc_next;
        s3_instr    = $urandom;
        s3_wdata    = wdata;
        s3_rd       = rd;
        s3_lsu_op   = lsu;
        s3_csr_op   = cop;
        s3_csr_addr = caddr;
        s3_cfu_op   = cfu;
        s3_wb_op    = wb_op;
        s3_trap     = trap;
        int_pending = irq;
        prev_live   = 1'b1;
        prev_mret   = (cfu == CFU_OP_MRET);
        prev_pc     = s3_pc;
        prev_instr  = s3_instr;
        #8;
        check_bit("instr_ret", instr_ret, 1'b0);
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [`CORE_XLEN-1:0] exp);
        csr_op_t cop;
        cop    = '0;
        cop.rd = 1'b1;
        send_instr(WB_OP_CSR, 64'd0, 5'd20, NO_LSU, cop, addr, CFU_OP_NONE, 1'b0, 1'b0);
        check_bit("s3_rd_wen", s3_rd_wen, 1'b1);
        check_data("s3_rd_wdata", s3_rd_wdata, exp);
        next_cycle();
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------

    task automatic run_alu_writeback();
        logic [`CORE_XLEN-1:0] data;
        data = {$urandom, $urandom};
        send_instr(WB_OP_WDATA, data, 5'd7, NO_LSU, NO_CSR, 12'h0, CFU_OP_NONE, 1'b0, 1'b0);
        check_bit("s3_rd_wen", s3_rd_wen, 1'b1);
        check_addr("s3_rd_addr", s3_rd_addr, 5'd7);
        check_data("s3_rd_wdata", s3_rd_wdata, data);
        next_cycle();
        #8;
        check_bit("s3_rd_wen", s3_rd_wen, 1'b0);     // Single pulse only
        next_cycle();
        send_instr(WB_OP_NONE, data, 5'd9, NO_LSU, NO_CSR, 12'h0, CFU_OP_NONE, 1'b0, 1'b0);
        check_bit("s3_rd_wen", s3_rd_wen, 1'b0);
        next_cycle();
    endtask

    task automatic run_load_align();
        logic [`CORE_XLEN-1:0] word;
        lsu_op_t               lsu;
        for (int size = 0; size < 4; size++) begin
            for (int off = 0; off < 8; off++) begin
                for (int sx = 0; sx < 2; sx++) begin
                    word       = {$urandom, $urandom};
                    dmem_rdata = word;
                    lsu        = '0;
                    lsu.is_load = 1'b1;
                    lsu.sext    = sx[0];
                    case (size)
                        0:       lsu.is_byte   = 1'b1;
                        1:       lsu.is_half   = 1'b1;
                        2:       lsu.is_word   = 1'b1;
                        default: lsu.is_double = 1'b1;
                    endcase
                    send_instr(WB_OP_LSU, 64'h0000_0000_8000_1000 + off, 5'd10, lsu,
                               NO_CSR, 12'h0, CFU_OP_NONE, 1'b0, 1'b0);
                    check_bit("s3_rd_wen", s3_rd_wen, 1'b1);
                    check_data("s3_rd_wdata", s3_rd_wdata,
                               aligned_load(word, off, 1 << size, sx[0]));
                    next_cycle();
                end
            end
        end
    endtask

    task automatic run_csr_access();
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] c;
        csr_op_t               cop;
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        c = {$urandom, $urandom};
        cop    = '0;
        cop.wr = 1'b1;
        send_instr(WB_OP_NONE, a, 5'd0, NO_LSU, cop, `CSR_ADDR_MSCRATCH, CFU_OP_NONE,
                   1'b0, 1'b0);
        check_bit("s3_rd_wen", s3_rd_wen, 1'b0);
        next_cycle();
        read_csr(`CSR_ADDR_MSCRATCH, a);
        cop     = '0;
        cop.set = 1'b1;
        send_instr(WB_OP_CSR, b, 5'd11, NO_LSU, cop, `CSR_ADDR_MSCRATCH, CFU_OP_NONE,
                   1'b0, 1'b0);
        check_data("s3_rd_wdata", s3_rd_wdata, a);   // Old value
        next_cycle();
        cop     = '0;
        cop.clr = 1'b1;
        send_instr(WB_OP_CSR, c, 5'd12, NO_LSU, cop, `CSR_ADDR_MSCRATCH, CFU_OP_NONE,
                   1'b0, 1'b0);
        check_data("s3_rd_wdata", s3_rd_wdata, a | b);
        next_cycle();
        read_csr(`CSR_ADDR_MSCRATCH, (a | b) & ~c);
    endtask

    task automatic run_illegal_csr();
        logic [`CORE_XLEN-1:0] bad_pc;
        csr_op_t               cop;
        cop    = '0;
        cop.rd = 1'b1;
        send_instr(WB_OP_CSR, 64'd0, 5'd12, NO_LSU, cop, 12'h7c0, CFU_OP_NONE, 1'b0, 1'b0);
        bad_pc = s3_pc;
        for (int i = 0; i < 5; i++) begin             // Ack held back
            if (i > 0) begin
                next_cycle();
                #8;
            end
            check_bit("s3_cf_valid", s3_cf_valid, 1'b1);
            check_bit("s3_ready", s3_ready, 1'b0);
            check_bit("trap_cpu", trap_cpu, 1'b1);
            check_bit("s3_rd_wen", s3_rd_wen, 1'b0);
            check_bit("instr_ret", instr_ret, 1'b0);
            check_data("s3_cf_target", s3_cf_target, `CORE_MTVEC_RESET);
            check_cause("trap_cause", trap_cause, 7'd2);
        end
        next_cycle();
        s3_cf_ack = 1'b1;
        #8;
        check_bit("instr_ret", instr_ret, 1'b1);      // Trapped instr retires here
        check_data("trs_pc", trs_pc, bad_pc);
        check_data("trap_pc", trap_pc, bad_pc);
        check_bit("trap_int", trap_int, 1'b0);
        next_cycle();
        s3_cf_ack = 1'b0;
        #8;
        check_bit("s3_cf_valid", s3_cf_valid, 1'b0);
        check_bit("s3_ready", s3_ready, 1'b1);
        prev_live = 1'b0;
        next_cycle();
        read_csr(`CSR_ADDR_MCAUSE, 64'd2);
        read_csr(`CSR_ADDR_MEPC, bad_pc);
    endtask

    task automatic run_interrupt();
        int_cause = 7'd11;
        int_tvec  = {$urandom, $urandom} & ~64'h3;
        send_instr(WB_OP_NONE, 64'd0, 5'd3, NO_LSU, NO_CSR, 12'h0, CFU_OP_NONE, 1'b1, 1'b1);
        for (int i = 0; i < 2; i++) begin
            if (i > 0) begin
                next_cycle();
                #8;
            end
            check_bit("s3_cf_valid", s3_cf_valid, 1'b1);
            check_bit("trap_cpu", trap_cpu, 1'b0);    // Interrupt wins
            check_bit("int_ack", int_ack, 1'b0);
            check_data("s3_cf_target", s3_cf_target, int_tvec);
            check_cause("trap_cause", trap_cause, int_cause);
        end
        next_cycle();
        s3_cf_ack = 1'b1;
        #8;
        check_bit("int_ack", int_ack, 1'b1);
        check_bit("trap_int", trap_int, 1'b1);
        check_cause("trap_cause", trap_cause, int_cause);
        next_cycle();
        s3_cf_ack   = 1'b0;
        int_pending = 1'b0;
        #8;
        check_bit("s3_cf_valid", s3_cf_valid, 1'b0);
        next_cycle();
        read_csr(`CSR_ADDR_MCAUSE, {57'd0, int_cause});
    endtask

    task automatic run_retire();
        send_instr(WB_OP_NONE, 64'd0, 5'd0, NO_LSU, NO_CSR, 12'h0, CFU_OP_MRET, 1'b0, 1'b0);
        next_cycle();
        send_instr(WB_OP_WDATA, {$urandom, $urandom}, 5'd13, NO_LSU, NO_CSR, 12'h0,
                   CFU_OP_NONE, 1'b0, 1'b0);
        next_cycle();
        send_instr(WB_OP_NONE, 64'd0, 5'd0, NO_LSU, NO_CSR, 12'h0, CFU_OP_NONE, 1'b0, 1'b0);
        next_cycle();
    endtask

    initial begin
        void'($urandom(SEED));
        s3_valid    = 1'b0;
        s3_full     = 1'b0;
        s3_pc       = '0;
        s3_instr    = '0;
        s3_wdata    = '0;
        s3_rd       = '0;
        s3_lsu_op   = '0;
        s3_csr_op   = '0;
        s3_csr_addr = '0;
        s3_cfu_op   = CFU_OP_NONE;
        s3_wb_op    = WB_OP_NONE;
        s3_trap     = 1'b0;
        dmem_rdata  = '0;
        int_pending = 1'b0;
        int_cause   = '0;
        int_tvec    = '0;
        s3_cf_ack   = 1'b0;
        wait (g_resetn === 1'b1);
        next_cycle();
        #8;
        check_bit("s3_rd_wen", s3_rd_wen, 1'b0);
        check_bit("s3_cf_valid", s3_cf_valid, 1'b0);
        check_bit("csr_en", i_dut.i_csr_if.csr_en, 1'b0);
        check_bit("int_ack", int_ack, 1'b0);
        check_bit("instr_ret", instr_ret, 1'b0);
        check_bit("trs_valid", trs_valid, 1'b0);
        next_cycle();
        run_alu_writeback();
        run_load_align();
        run_csr_access();
        run_illegal_csr();
        run_interrupt();
        run_retire();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/core_wb_pkg.sv
hdl/wb_csr_if.sv
hdl/wb_load_align.sv
hdl/wb_csr_unit.sv
hdl/wb_commit.sv
hdl/core_wb_top.sv
sim/tb_clkgen.sv
sim/tb_core_wb.sv

// File: Bender.yml
package:
  name: core_wb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_wb_pkg.sv
      - hdl/wb_csr_if.sv
      - hdl/wb_load_align.sv
      - hdl/wb_csr_unit.sv
      - hdl/wb_commit.sv
      - hdl/core_wb_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_clkgen.sv
      - sim/tb_core_wb.sv
